/* lsu_subsystem.f */
+incdir+tb
design/lsu_pkg.sv
design/data_sram.sv
design/axi_read_slave.sv
design/axi_write_slave.sv
design/lsu.sv
design/lsu_subsystem.sv
tb/tb_lsu_subsystem.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_lsu_subsystem \
  -f lsu_subsystem.f -o sim_lsu_subsystem
./obj_dir/sim_lsu_subsystem > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
  exit 0
fi
exit 1

/* tb/lsu_model.svh */
`ifndef LSU_MODEL_SVH
`define LSU_MODEL_SVH

localparam int MIRROR_BYTES = MEM_WORDS * 4;
localparam int MIRROR_AW    = $clog2(MIRROR_BYTES);

logic [7:0] mirror [MIRROR_BYTES]; // byte view of the sram

function automatic int size_bytes(input lsu_size_e size);
  case (size)
    SIZE_BYTE: return 1;
    SIZE_HALF: return 2;
    default:   return 4;
  endcase
endfunction

function automatic logic addr_in_range(input addr_t addr);
  return addr < addr_t'(MIRROR_BYTES);
endfunction

function automatic logic expected_fault(input addr_t addr);
  return !addr_in_range(addr);
endfunction

// low bytes of wdata go to addr upward
function automatic void store_to_mirror(input addr_t addr, input lsu_size_e size,
                                        input data_t wdata);
  logic [MIRROR_AW-1:0] idx;
  if (!addr_in_range(addr)) return; // write slave drops it
  for (int i = 0; i < size_bytes(size); i++) begin
    idx = MIRROR_AW'(addr + addr_t'(i));
    mirror[idx] = wdata[8*i +: 8];
  end
endfunction

function automatic data_t expected_load(input addr_t addr, input lsu_size_e size,
                                        input logic sext);
  data_t                value;
  logic [MIRROR_AW-1:0] idx;
  int                   n;
  value = '0;
  n     = size_bytes(size);
  if (!addr_in_range(addr)) return '0; // faulting load reads zero
  for (int i = 0; i < n; i++) begin
    idx = MIRROR_AW'(addr + addr_t'(i));
    value[8*i +: 8] = mirror[idx];
  end
  if (sext && value[8*n-1]) begin
    for (int i = n; i < 4; i++) value[8*i +: 8] = 8'hff;
  end
  return value;
endfunction

`endif

/* tb/tb_lsu_subsystem.sv */
`timescale 1ns/1ps

module tb_lsu_subsystem;
  import lsu_pkg::*;

  localparam int MEM_WORDS       = 256;
  localparam int READ_LATENCY    = 2;
  localparam int PERIOD          = 40;
  localparam int RESET_CYCLES    = 16;
  localparam logic [31:0] SEED   = 32'h9eb4d6b5;
  localparam int TEST_WORDS      = 16;
  localparam int SWEEP_WORDS     = 2;
  localparam int PARTIAL_WORD    = 3;
  localparam int N_RANDOM        = 200;
  // fill, sweep, partial stores, range tests, random mix
  localparam int N_REQS          = TEST_WORDS + SWEEP_WORDS * 13 + 12 + 8 + N_RANDOM;
  localparam int WATCHDOG_CYCLES = N_REQS * 40 + RESET_CYCLES;

  logic      clock = 1'b0;
  logic      reset;
  lsu_req_t  req;
  logic      req_valid;
  logic      req_ready;
  lsu_resp_t resp;
  logic      resp_valid;
  logic      resp_ready = 1'b1;

  logic [31:0] stim_state  = SEED;
  logic [31:0] stall_state = ~SEED; // separate stream for resp_ready
  logic        stalls_on;
  trans_id_t   next_id;

  lsu_resp_t exp_queue [$];
  lsu_resp_t exp_front;
  logic      exp_pending = 1'b0;
  int        errors      = 0;
  int        requests    = 0;
  int        responses   = 0;

  `include "lsu_model.svh"

  lsu_subsystem #(
    .MEM_WORDS    (MEM_WORDS),
    .READ_LATENCY (READ_LATENCY)
  ) u_dut (
    .clock      (clock),
    .reset      (reset),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
  );

  always #(PERIOD / 2) clock = ~clock;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  always @(negedge clock) begin
    if (stalls_on) begin
      stall_state = xorshift32(stall_state);
      resp_ready  = |stall_state[1:0]; // ready three cycles in four
    end else begin
      resp_ready = 1'b1;
    end
  end

  // mirror follows each store accept
  always @(posedge clock) begin
    lsu_resp_t expect_resp;
    if (reset) begin
      exp_queue.delete();
      exp_pending <= 1'b0;
    end else begin
      if (resp_valid && resp_ready) begin
        responses++;
        if (exp_queue.size() > 0) void'(exp_queue.pop_front());
      end
      if (req_valid && req_ready) begin
        requests++;
        expect_resp.trans_id = req.trans_id;
        if (req.write) begin
          expect_resp.rdata = '0;
          expect_resp.fault = 1'b0;
          store_to_mirror(req.addr, req.size, req.wdata);
        end else begin
          expect_resp.rdata = expected_load(req.addr, req.size, req.sext);
          expect_resp.fault = expected_fault(req.addr);
        end
        exp_queue.push_back(expect_resp);
      end
      exp_pending <= (exp_queue.size() > 0);
      if (exp_queue.size() > 0) exp_front <= exp_queue[0];
    end
  end

  a_reset_ready: assert property (@(posedge clock) $fell(reset) |-> req_ready)
    else begin
      errors += 1;
      $display("[FAIL] req_ready expected 1 got %h", $sampled(req_ready));
    end

  a_reset_resp: assert property (@(posedge clock) $fell(reset) |-> !resp_valid)
    else begin
      errors += 1;
      $display("[FAIL] resp_valid expected 0 got %h", $sampled(resp_valid));
    end

  a_store_timing: assert property (@(posedge clock) disable iff (reset)
    req_valid && req_ready && req.write |=> resp_valid)
    else begin
      errors += 1;
      $display("store response did not arrive one cycle after the accept");
    end

  a_resp_expected: assert property (@(posedge clock) disable iff (reset)
    resp_valid && resp_ready |-> exp_pending)
    else begin
      errors += 1;
      $display("response taken while no request was outstanding");
    end

  a_resp_rdata: assert property (@(posedge clock) disable iff (reset)
    resp_valid && resp_ready && exp_pending |-> resp.rdata == exp_front.rdata)
    else begin
      errors += 1;
      $display("[FAIL] resp.rdata expected %h got %h",
               $sampled(exp_front.rdata), $sampled(resp.rdata));
    end

  a_resp_id: assert property (@(posedge clock) disable iff (reset)
    resp_valid && resp_ready && exp_pending |-> resp.trans_id == exp_front.trans_id)
    else begin
      errors += 1;
      $display("[FAIL] resp.trans_id expected %h got %h",
               $sampled(exp_front.trans_id), $sampled(resp.trans_id));
    end

  a_resp_fault: assert property (@(posedge clock) disable iff (reset)
    resp_valid && resp_ready && exp_pending |-> resp.fault == exp_front.fault)
    else begin
      errors += 1;
      $display("[FAIL] resp.fault expected %h got %h",
               $sampled(exp_front.fault), $sampled(resp.fault));
    end

  a_resp_hold: assert property (@(posedge clock) disable iff (reset)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp))
    else begin
      errors += 1;
      $display("response dropped or changed while resp_ready was low");
    end

  a_busy: assert property (@(posedge clock) disable iff (reset) resp_valid |-> !req_ready)
    else begin
      errors += 1;
      $display("req_ready went high while a response was still pending");
    end

  task automatic send(input addr_t addr, input lsu_size_e size, input logic sext,
                      input logic write, input data_t wdata);
    req = '{addr: addr, size: size, sext: sext, write: write, wdata: wdata,
            trans_id: next_id};
    next_id   = next_id + 4'd1;
    req_valid = 1'b1;
    while (!req_ready) @(negedge clock);
    @(negedge clock); // taken on the rising edge just passed
    req_valid = 1'b0;
  endtask

  task automatic random_request();
    logic [31:0] r;
    lsu_size_e   size;
    int          word;
    int          off;
    addr_t       addr;
    stim_state = xorshift32(stim_state);
    r    = stim_state;
    word = int'(r[3:0]) % TEST_WORDS;
    case (r[5:4])
      2'd0:    size = SIZE_BYTE;
      2'd1:    size = SIZE_HALF;
      default: size = SIZE_WORD;
    endcase
    if (size == SIZE_BYTE) off = int'(r[7:6]);
    else if (size == SIZE_HALF) off = int'(r[7]) * 2;
    else off = 0;
    addr = addr_t'(word * 4 + off);
    if (r[12:10] == 3'd0) addr = addr + addr_t'(MEM_WORDS * 4); // beyond the sram
    stim_state = xorshift32(stim_state);
    send(addr, size, r[8], r[9], stim_state);
  endtask

  initial begin
    int late_errors;
    late_errors = 0;
    reset     = 1'b1;
    req       = '0;
    req_valid = 1'b0;
    stalls_on = 1'b0;
    next_id   = '0;
    repeat (RESET_CYCLES) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);

    for (int w = 0; w < TEST_WORDS; w++) begin
      stim_state = xorshift32(stim_state);
      send(addr_t'(w * 4), SIZE_WORD, 1'b0, 1'b1, stim_state);
    end

    // each size at each offset it may take, signed and unsigned
    for (int w = 0; w < SWEEP_WORDS; w++) begin
      for (int s = 0; s < 2; s++) begin
        for (int off = 0; off < 4; off++) begin
          send(addr_t'(w * 4 + off), SIZE_BYTE, s[0], 1'b0, '0);
        end
        for (int off = 0; off < 4; off += 2) begin
          send(addr_t'(w * 4 + off), SIZE_HALF, s[0], 1'b0, '0);
        end
      end
      send(addr_t'(w * 4), SIZE_WORD, 1'b0, 1'b0, '0);
    end

    // whole-word load after each partial store shows the neighbors
    for (int off = 0; off < 4; off++) begin
      stim_state = xorshift32(stim_state);
      send(addr_t'(PARTIAL_WORD * 4 + off), SIZE_BYTE, 1'b0, 1'b1, stim_state);
      send(addr_t'(PARTIAL_WORD * 4), SIZE_WORD, 1'b0, 1'b0, '0);
    end
    for (int off = 0; off < 4; off += 2) begin
      stim_state = xorshift32(stim_state);
      send(addr_t'(PARTIAL_WORD * 4 + off), SIZE_HALF, 1'b0, 1'b1, stim_state);
      send(addr_t'(PARTIAL_WORD * 4), SIZE_WORD, 1'b0, 1'b0, '0);
    end

    send(addr_t'(MEM_WORDS * 4), SIZE_WORD, 1'b0, 1'b0, '0);
    send(addr_t'(MEM_WORDS * 4 + 5), SIZE_BYTE, 1'b1, 1'b0, '0);
    send(addr_t'(MEM_WORDS * 8 + 2), SIZE_HALF, 1'b1, 1'b0, '0);
    send(32'hffff_fffc, SIZE_WORD, 1'b0, 1'b0, '0);
    // these alias words 5 and 6 in the index bits
    send(addr_t'(MEM_WORDS * 4 + 20), SIZE_WORD, 1'b0, 1'b1, 32'h5a5a_c3c3);
    send(addr_t'(20), SIZE_WORD, 1'b0, 1'b0, '0);
    send(addr_t'(MEM_WORDS * 8 + 24), SIZE_WORD, 1'b0, 1'b1, 32'h0f0f_9696);
    send(addr_t'(24), SIZE_WORD, 1'b0, 1'b0, '0);

    stalls_on = 1'b1;
    repeat (N_RANDOM) random_request();

    while (exp_queue.size() != 0) @(negedge clock);
    stalls_on = 1'b0;
    repeat (2) @(negedge clock);

    if (requests != N_REQS) begin
      late_errors++;
      $display("only %0d of %0d requests were accepted", requests, N_REQS);
    end
    $display("requests %0d, responses %0d, errors %0d",
             requests, responses, errors + late_errors);
    if (errors + late_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * PERIOD);
    $display("watchdog expired after %0d cycles, the DUT stopped answering", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

/* design/lsu_subsystem.sv */
`timescale 1ns/1ps

module lsu_subsystem #(
  parameter int MEM_WORDS    = 256,
  parameter int READ_LATENCY = 2
) (
  input  logic               clock,
  input  logic               reset,
  input  lsu_pkg::lsu_req_t  req,
  input  logic               req_valid,
  output logic               req_ready,
  output lsu_pkg::lsu_resp_t resp,
  output logic               resp_valid,
  input  logic               resp_ready
);
  import lsu_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  axi_r_m2s_t r_m2s;
  axi_r_s2m_t r_s2m;
  axi_w_m2s_t w_m2s;
  axi_w_s2m_t w_s2m;

  logic             rd_en;
  logic [IDX_W-1:0] rd_index;
  data_t            rd_data;
  logic             wr_en;
  logic [IDX_W-1:0] wr_index;
  data_t            wr_data;
  strb_t            wr_strb;

  lsu u_lsu (
    .clock      (clock),
    .reset      (reset),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .r_m2s      (r_m2s),
    .r_s2m      (r_s2m),
    .w_m2s      (w_m2s),
    .w_s2m      (w_s2m)
  );

  axi_read_slave #(
    .MEM_WORDS    (MEM_WORDS),
    .READ_LATENCY (READ_LATENCY)
  ) u_read_slave (
    .clock    (clock),
    .reset    (reset),
    .r_m2s    (r_m2s),
    .r_s2m    (r_s2m),
    .rd_en    (rd_en),
    .rd_index (rd_index),
    .rd_data  (rd_data)
  );

  axi_write_slave #(
    .MEM_WORDS (MEM_WORDS)
  ) u_write_slave (
    .clock    (clock),
    .reset    (reset),
    .w_m2s    (w_m2s),
    .w_s2m    (w_s2m),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_data  (wr_data),
    .wr_strb  (wr_strb)
  );

  // reads from one slave, writes from the other
  data_sram #(
    .MEM_WORDS (MEM_WORDS)
  ) u_sram (
    .clock    (clock),
    .rd_en    (rd_en),
    .rd_index (rd_index),
    .rd_data  (rd_data),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_data  (wr_data),
    .wr_strb  (wr_strb)
  );

endmodule

/* design/lsu.sv */
`timescale 1ns/1ps

module lsu (
  input  logic               clock,
  input  logic               reset,
  input  lsu_pkg::lsu_req_t  req,
  input  logic               req_valid,
  output logic               req_ready,
  output lsu_pkg::lsu_resp_t resp,
  output logic               resp_valid,
  input  logic               resp_ready,
  output lsu_pkg::axi_r_m2s_t r_m2s,
  input  lsu_pkg::axi_r_s2m_t r_s2m,
  output lsu_pkg::axi_w_m2s_t w_m2s,
  input  lsu_pkg::axi_w_s2m_t w_s2m
);
  import lsu_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT_B,
    S_WAIT_R,
    S_RESP
  } lsu_state_e;

  lsu_state_e state;

  logic arvalid_q;
  logic rready_q;
  logic awvalid_q;
  logic wvalid_q;
  logic bready_q;

  addr_t     addr_q;
  data_t     wdata_q;
  strb_t     wstrb_q;
  lsu_size_e size_q;
  logic      sext_q;

  logic  accept;
  logic  r_done;
  logic  b_done;
  logic  resp_done;
  strb_t strb_base;

  // pick the lanes, then sign or zero fill the rest
  function automatic data_t load_extend(input data_t word, input logic [1:0] off,
                                        input lsu_size_e size, input logic sext);
    data_t shifted;
    shifted = word >> {off, 3'b000};
    unique case (size)
      SIZE_BYTE: return {{24{sext & shifted[7]}}, shifted[7:0]};
      SIZE_HALF: return {{16{sext & shifted[15]}}, shifted[15:0]};
      default:   return shifted;
    endcase
  endfunction

  assign req_ready = (state == S_IDLE);
  assign accept    = req_valid && req_ready;
  assign r_done    = rready_q && r_s2m.rvalid;
  assign b_done    = bready_q && w_s2m.bvalid;
  assign resp_done = resp_valid && resp_ready;

  always_comb begin
    unique case (req.size)
      SIZE_BYTE: strb_base = 4'b0001;
      SIZE_HALF: strb_base = 4'b0011;
      SIZE_WORD: strb_base = 4'b1111;
      default:   strb_base = 4'b0000;
    endcase
  end

  assign r_m2s = '{arvalid: arvalid_q, araddr: addr_q, rready: rready_q};
  assign w_m2s = '{awvalid: awvalid_q, awaddr: addr_q, wvalid: wvalid_q,
                   wdata: wdata_q, wstrb: wstrb_q, bready: bready_q};

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= S_IDLE;
      arvalid_q  <= 1'b0;
      rready_q   <= 1'b0;
      awvalid_q  <= 1'b0;
      wvalid_q   <= 1'b0;
      bready_q   <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      unique case (state)
        S_IDLE: begin
          if (accept && req.write) begin
            awvalid_q  <= 1'b1;
            wvalid_q   <= 1'b1;
            resp_valid <= 1'b1; // stores are posted
            state      <= S_WAIT_B;
          end else if (accept) begin
            arvalid_q <= 1'b1;
            state     <= S_WAIT_R;
          end
        end
        S_WAIT_B: begin
          if (awvalid_q && w_s2m.awready) awvalid_q <= 1'b0;
          if (wvalid_q && w_s2m.wready) wvalid_q <= 1'b0;
          if (w_s2m.bvalid && !bready_q) bready_q <= 1'b1;
          if (resp_done) resp_valid <= 1'b0;
          if (b_done) begin
            bready_q <= 1'b0;
            state    <= (resp_valid && !resp_ready) ? S_RESP : S_IDLE;
          end
        end
        S_WAIT_R: begin
          if (arvalid_q && r_s2m.arready) begin
            arvalid_q <= 1'b0;
            rready_q  <= 1'b1;
          end
          if (r_done) begin
            rready_q   <= 1'b0;
            resp_valid <= 1'b1;
            state      <= S_RESP;
          end
        end
        S_RESP: begin
          if (resp_done) begin
            resp_valid <= 1'b0;
            state      <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // request and response payload
  always_ff @(posedge clock) begin
    if (accept) begin
      addr_q        <= req.addr;
      size_q        <= req.size;
      sext_q        <= req.sext;
      wdata_q       <= req.wdata << {req.addr[1:0], 3'b000};
      wstrb_q       <= strb_base << req.addr[1:0];
      resp.rdata    <= '0;
      resp.fault    <= 1'b0;
      resp.trans_id <= req.trans_id;
    end else if (r_done) begin
      resp.rdata <= load_extend(r_s2m.rdata, addr_q[1:0], size_q, sext_q);
      resp.fault <= (r_s2m.rresp == RESP_SLVERR);
    end
  end

  a_arvalid_hold: assert property (@(posedge clock) disable iff (reset)
    r_m2s.arvalid && !r_s2m.arready |=> r_m2s.arvalid)
    else $error("arvalid dropped before arready");

  a_resp_stable: assert property (@(posedge clock) disable iff (reset)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp))
    else $error("response changed while stalled");

  a_size_legal: assert property (@(posedge clock) disable iff (reset)
    accept |-> req.size inside {SIZE_BYTE, SIZE_HALF, SIZE_WORD})
    else $error("illegal access size accepted");

endmodule

/* design/axi_write_slave.sv */
`timescale 1ns/1ps

module axi_write_slave #(
  parameter int MEM_WORDS = 256
) (
  input  logic                         clock,
  input  logic                         reset,
  input  lsu_pkg::axi_w_m2s_t          w_m2s,
  output lsu_pkg::axi_w_s2m_t          w_s2m,
  output logic                         wr_en,
  output logic [$clog2(MEM_WORDS)-1:0] wr_index,
  output lsu_pkg::data_t               wr_data,
  output lsu_pkg::strb_t               wr_strb
);
  import lsu_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic aw_got;    // address beat captured
  logic w_got;     // data beat captured
  logic wr_done_q;
  logic err_q;

  logic [IDX_W-1:0] idx_q;
  data_t            data_q;
  strb_t            strb_q;

  logic aw_fire;
  logic w_fire;
  logic both;
  logic b_fire;

  assign aw_fire = w_m2s.awvalid && !aw_got;
  assign w_fire  = w_m2s.wvalid && !w_got;
  assign both    = aw_got && w_got;
  assign b_fire  = both && w_m2s.bready;

  always_ff @(posedge clock) begin
    if (reset) begin
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      wr_done_q <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      if (aw_fire) begin
        aw_got <= 1'b1;
        err_q  <= !(w_m2s.awaddr[31:2] < 30'(MEM_WORDS));
      end
      if (w_fire) w_got <= 1'b1;
      if (both && !wr_done_q) wr_done_q <= 1'b1;
      if (b_fire) begin
        aw_got    <= 1'b0;
        w_got     <= 1'b0;
        wr_done_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (aw_fire) idx_q <= w_m2s.awaddr[IDX_W+1:2];
    if (w_fire) begin
      data_q <= w_m2s.wdata;
      strb_q <= w_m2s.wstrb;
    end
  end

  // one write per transaction and none out of range
  assign wr_en    = both && !wr_done_q && !err_q;
  assign wr_index = idx_q;
  assign wr_data  = data_q;
  assign wr_strb  = strb_q;

  assign w_s2m = '{awready: !aw_got,
                   wready:  !w_got,
                   bvalid:  both,
                   bresp:   err_q ? RESP_SLVERR : RESP_OKAY};

  a_b_after_beats: assert property (@(posedge clock) disable iff (reset)
    $rose(w_s2m.bvalid) |->
      $past(aw_got || (w_m2s.awvalid && w_s2m.awready)) &&
      $past(w_got || (w_m2s.wvalid && w_s2m.wready)))
    else $error("bvalid raised before both aw and w transferred");

endmodule

/* design/axi_read_slave.sv */
`timescale 1ns/1ps

module axi_read_slave #(
  parameter int MEM_WORDS    = 256,
  parameter int READ_LATENCY = 2
) (
  input  logic                         clock,
  input  logic                         reset,
  input  lsu_pkg::axi_r_m2s_t          r_m2s,
  output lsu_pkg::axi_r_s2m_t          r_s2m,
  output logic                         rd_en,
  output logic [$clog2(MEM_WORDS)-1:0] rd_index,
  input  lsu_pkg::data_t               rd_data
);
  import lsu_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int CNT_W = $clog2(READ_LATENCY + 1);

  typedef enum logic [1:0] {
    R_IDLE,
    R_WAIT,
    R_RESP
  } rd_state_e;

  rd_state_e        state;
  logic [CNT_W-1:0] cnt;
  logic             err_q;
  logic [IDX_W-1:0] idx_q;
  logic             ar_fire;
  logic             in_range;

  assign ar_fire  = r_m2s.arvalid && (state == R_IDLE);
  assign in_range = r_m2s.araddr[31:2] < 30'(MEM_WORDS);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= R_IDLE;
      cnt   <= '0;
      err_q <= 1'b0;
    end else begin
      unique case (state)
        R_IDLE: begin
          if (ar_fire) begin
            cnt   <= CNT_W'(READ_LATENCY - 1);
            err_q <= !in_range;
            state <= R_WAIT;
          end
        end
        R_WAIT: begin
          if (cnt == '0) state <= R_RESP; // sram read issued this cycle
          else cnt <= cnt - 1'b1;
        end
        R_RESP: begin
          if (r_m2s.rready) state <= R_IDLE;
        end
        default: state <= R_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) idx_q <= r_m2s.araddr[IDX_W+1:2];
  end

  assign rd_en    = (state == R_WAIT) && (cnt == '0) && !err_q;
  assign rd_index = idx_q;

  // sram output holds while no new read is issued
  assign r_s2m = '{arready: (state == R_IDLE),
                   rvalid:  (state == R_RESP),
                   rdata:   err_q ? '0 : rd_data,
                   rresp:   err_q ? RESP_SLVERR : RESP_OKAY};

  a_rdata_stable: assert property (@(posedge clock) disable iff (reset)
    r_s2m.rvalid && !r_m2s.rready |=> $stable(r_s2m.rdata) && $stable(r_s2m.rresp))
    else $error("rdata changed while rvalid stalled");

endmodule

/* design/data_sram.sv */
`timescale 1ns/1ps

module data_sram #(
  parameter int MEM_WORDS = 256
) (
  input  logic                         clock,
  input  logic                         rd_en,
  input  logic [$clog2(MEM_WORDS)-1:0] rd_index,
  output lsu_pkg::data_t               rd_data,
  input  logic                         wr_en,
  input  logic [$clog2(MEM_WORDS)-1:0] wr_index,
  input  lsu_pkg::data_t               wr_data,
  input  lsu_pkg::strb_t               wr_strb
);
  import lsu_pkg::*;

  localparam int LANES = $bits(strb_t);

  data_t mem [MEM_WORDS];

  // byte lanes from the write slave
  always_ff @(posedge clock) begin
    if (wr_en) begin
      for (int i = 0; i < LANES; i++) begin
        if (wr_strb[i]) mem[wr_index][8*i +: 8] <= wr_data[8*i +: 8];
      end
    end
  end

  // registered read gives the old word on a same-cycle write
  always_ff @(posedge clock) begin
    if (rd_en) rd_data <= mem[rd_index];
  end

endmodule

/* design/lsu_pkg.sv */
package lsu_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;     // one bit per byte lane
  typedef logic [3:0]  trans_id_t; // scoreboard tag
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // 2'd3 is illegal
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } lsu_size_e;

  typedef struct packed {
    addr_t     addr;
    lsu_size_e size;
    logic      sext;  // 1 = sign extend the load
    logic      write;
    data_t     wdata; // unshifted, in the low lanes
    trans_id_t trans_id;
  } lsu_req_t;

  typedef struct packed {
    data_t     rdata;
    trans_id_t trans_id;
    logic      fault;
  } lsu_resp_t;

  typedef struct packed {
    logic  awvalid;
    addr_t awaddr;
    logic  wvalid;
    data_t wdata;
    strb_t wstrb;
    logic  bready;
  } axi_w_m2s_t;

  typedef struct packed {
    logic  awready;
    logic  wready;
    logic  bvalid;
    resp_t bresp;
  } axi_w_s2m_t;

  typedef struct packed {
    logic  arvalid;
    addr_t araddr;
    logic  rready;
  } axi_r_m2s_t;

  typedef struct packed {
    logic  arready;
    logic  rvalid;
    data_t rdata;
    resp_t rresp;
  } axi_r_s2m_t;

endpackage
